/* dv/dsp_vectors.txt */
# columns: we cfg_word codes est_lane3 est_lane2 est_lane1 est_lane0 checked mask
# expected outputs are those seen just after the edge capturing the line, mask 1=est 2=checked
1 00001 00000000 000 000 000 000 0 3
1 10001 00000000 000 000 000 000 F 3
1 20001 00000000 000 000 000 000 F 3
1 30001 00000000 000 000 000 000 F 3
0 00000 28E2140A 000 000 000 000 F 3
1 01002 08070605 028 3E2 014 00A F 3
1 21001 04030201 008 007 006 055 F 3
1 3007F 64000000 004 005 002 011 B 3
1 B0004 9C000000 1FF 000 000 008 F 3
1 40064 EC000000 200 000 000 0C8 F 3
1 50001 64000000 361 000 000 338 F 3
1 C0014 000000E7 1FF 000 000 3D8 7 3
1 C100A 00000000 000 000 000 0AF 4 3
0 00000 0A0A0A0A 000 000 000 000 D 3
0 00000 00000000 04F 014 00A 00A C 3
0 00000 00000000 000 000 000 014 C 3
0 00000 00000000 000 000 000 000 E 3

/* vlog.f */
+incdir+common
common/dsp_pkg.sv
hdl/dsp_config_regs.sv
hdl/code_history.sv
ffe/ffe_datapath.sv
hdl/decision_slicer.sv
mlsd/mlsd_checker.sv
hdl/dsp_backend.sv
dv/tb_clock_gen.sv
dv/dsp_backend_props.sv
dv/dsp_backend_tb.sv

/* Bender.yml */
package:
  name: dsp_backend

sources:
  - include_dirs:
      - common
    files:
      - common/dsp_pkg.sv
      - hdl/dsp_config_regs.sv
      - hdl/code_history.sv
      - ffe/ffe_datapath.sv
      - hdl/decision_slicer.sv
      - mlsd/mlsd_checker.sv
      - hdl/dsp_backend.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_clock_gen.sv
      - dv/dsp_backend_props.sv
      - dv/dsp_backend_tb.sv

/* dv/dsp_backend_tb.sv */
`timescale 1ns/10ps

module dsp_backend_tb
	import dsp_pkg::*;
();

	logic           clk;
	logic           rstb;
	logic           cfg_we;
	dsp_cfg_word_t  cfg_word;
	dsp_code_word_t codes;
	dsp_est_word_t  est;
	dsp_bits_t      checked;

	logic        v_we[$];
	logic [19:0] v_cfg[$];
	logic [31:0] v_code[$];
	logic [39:0] v_est[$];
	logic [3:0]  v_chk[$];
	logic [1:0]  v_mask[$];

	int errors;
	int checks;
	int nvec;
	int seed;
	bit loaded;

	tb_clock_gen u_clk (
		.clk_o (clk),
		.rstb_o(rstb)
	);

	dsp_backend dut (
		.clk             (clk),
		.rstb            (rstb),
		.codes_i         (codes),
		.cfg_we_i        (cfg_we),
		.cfg_word_i      (cfg_word),
		.estimated_bits_o(est),
		.checked_bits_o  (checked)
	);

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		logic we;
		logic [19:0] cw;
		logic [31:0] cd;
		logic [9:0] e3;
		logic [9:0] e2;
		logic [9:0] e1;
		logic [9:0] e0;
		logic [3:0] ck;
		logic [1:0] mk;
		fd = $fopen("dv/dsp_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file dv/dsp_vectors.txt");
			errors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
					we, cw, cd, e3, e2, e1, e0, ck, mk);
				if (n == 9) begin
					v_we.push_back(we);
					v_cfg.push_back(cw);
					v_code.push_back(cd);
					v_est.push_back({e3, e2, e1, e0});
					v_chk.push_back(ck);
					v_mask.push_back(mk);
				end
			end
		end
		$fclose(fd);
		if (v_we.size() == 0) begin
			$display("no vectors were read from dv/dsp_vectors.txt");
			errors++;
		end
	endtask

	task automatic drive_line(input int i);
		cfg_we   = v_we[i];
		cfg_word = v_cfg[i];
		codes    = v_code[i];
	endtask

	task automatic drive_idle();
		cfg_we   = 1'b0;
		cfg_word = '0;
		codes    = $random(seed);
	endtask

	// mask bit 0 selects the estimates and bit 1 the checked bits.
	task automatic check_line(input int i);
		logic [39:0] est_mask;
		logic [3:0] chk_mask;
		est_mask = v_mask[i][0] ? '1 : '0;
		chk_mask = v_mask[i][1] ? '1 : '0;
		checks++;
		assert (((est ^ v_est[i]) & est_mask) == '0) else begin
			$display("Mismatch estimated_bits_o line %0d: got %h, expected %h",
				i, est, v_est[i]);
			errors++;
		end
		assert (((checked ^ v_chk[i]) & chk_mask) == '0) else begin
			$display("Mismatch checked_bits_o line %0d: got %h, expected %h",
				i, checked, v_chk[i]);
			errors++;
		end
	endtask

	initial begin
		cfg_we   = 1'b0;
		cfg_word = '0;
		codes    = '0;
		errors   = 0;
		checks   = 0;
		seed     = 25579;
		load_vectors();
		nvec   = v_we.size();
		loaded = 1'b1;
		wait (rstb === 1'b1);
		if (nvec > 0) begin
			drive_line(0);
		end
		for (int i = 0; i < nvec; i++) begin
			@(posedge clk);
			#1;
			check_line(i);
			#4;
			if (i + 1 < nvec) begin
				drive_line(i + 1);
			end else begin
				drive_idle();
			end
		end
		// random idle words whose outputs are not compared.
		repeat (8) begin
			@(posedge clk);
			#5;
			drive_idle();
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		#((nvec + 20) * 100);
		$display("timeout, the run did not finish within %0d cycles", nvec + 20);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* dv/dsp_backend_props.sv */
`timescale 1ns/10ps
`include "dsp_cfg.svh"

module dsp_backend_props
	import dsp_pkg::*;
(
	input logic           clk,
	input logic           rstb,
	input dsp_code_hist_t hist_i,
	input dsp_weights_t   weights_i,
	input dsp_est_word_t  est_i,
	input dsp_bits_t      checked_i
);
	// sign of each tap product in the FFE window.
	logic [`DSP_WIDTH-1:0] has_neg;
	logic [`DSP_WIDTH-1:0] has_pos;

	always_comb begin
		dsp_code_t [2*`DSP_WIDTH-1:0] win;
		logic signed [2*`DSP_CODE_BITS-1:0] term;
		win = {hist_i[0], hist_i[1]};
		for (int l = 0; l < `DSP_WIDTH; l++) begin
			has_neg[l] = 1'b0;
			has_pos[l] = 1'b0;
			for (int k = 0; k < `DSP_FFE_TAPS; k++) begin
				term = win[`DSP_WIDTH + l - k] * weights_i[l][k];
				if (term < 0) begin
					has_neg[l] = 1'b1;
				end
				if (term > 0) begin
					has_pos[l] = 1'b1;
				end
			end
		end
	end

	reset_zero: assert property (@(posedge clk) !rstb |-> (est_i == '0 && checked_i == '0))
		else $error("outputs are not zero while in reset");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per lane saturation keeps the sign of the sum.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar l = 0; l < `DSP_WIDTH; l++) begin : g_lane
		est_not_below: assert property (@(posedge clk) disable iff (!rstb)
			!has_neg[l] |=> !est_i[l][`DSP_EST_BITS-1])
			else $error("estimate of lane %0d wrapped below zero", l);
		est_not_above: assert property (@(posedge clk) disable iff (!rstb)
			!has_pos[l] |=> (est_i[l][`DSP_EST_BITS-1] || est_i[l] == '0))
			else $error("estimate of lane %0d wrapped above zero", l);
	end

	// the first edge after reset still sees reset state in every stage.
	reset_release: assert property (@(posedge clk) $rose(rstb) |=> checked_i == '0)
		else $error("checked bits changed at the first edge after reset");

endmodule

bind dsp_backend dsp_backend_props u_props (
	.clk      (clk),
	.rstb     (rstb),
	.hist_i   (hist),
	.weights_i(weights),
	.est_i    (estimated_bits_o),
	.checked_i(checked_bits_o)
);

/* dv/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_o,
	output logic rstb_o
);

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	// release lines up with the 5 ns drive point after the third edge.
	initial begin
		rstb_o = 1'b0;
		repeat (3) @(posedge clk_o);
		#5;
		rstb_o = 1'b1;
	end

endmodule

/* hdl/dsp_backend.sv */
`timescale 1ns/10ps
`include "dsp_cfg.svh"

module dsp_backend
	import dsp_pkg::*;
(
	input  logic           clk,
	input  logic           rstb,
	input  dsp_code_word_t codes_i,
	input  logic           cfg_we_i,
	input  dsp_cfg_word_t  cfg_word_i,
	output dsp_est_word_t  estimated_bits_o,
	output dsp_bits_t      checked_bits_o
);

	dsp_weights_t     weights;
	dsp_thresh_word_t thresh;
	dsp_shift_word_t  ffe_shift;
	dsp_chest_t       chest;
	dsp_code_hist_t   hist;
	dsp_bits_t        sliced_bits;
	dsp_bits_t        sliced_prev;

	dsp_config_regs u_cfg (
		.clk        (clk),
		.rstb       (rstb),
		.cfg_we_i   (cfg_we_i),
		.cfg_word_i (cfg_word_i),
		.weights_o  (weights),
		.thresh_o   (thresh),
		.ffe_shift_o(ffe_shift),
		.chest_o    (chest)
	);

	code_history u_hist (
		.clk    (clk),
		.rstb   (rstb),
		.codes_i(codes_i),
		.hist_o (hist)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FFE on w0/w1, slicer, MLSD on the oldest word.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	ffe_datapath u_ffe (
		.clk      (clk),
		.rstb     (rstb),
		.cur_i    (hist[0]),
		.prev_i   (hist[1]),
		.weights_i(weights),
		.shift_i  (ffe_shift),
		.est_o    (estimated_bits_o)
	);

	decision_slicer u_slicer (
		.clk        (clk),
		.rstb       (rstb),
		.est_i      (estimated_bits_o),
		.thresh_i   (thresh),
		.bits_o     (sliced_bits),
		.prev_bits_o(sliced_prev)
	);

	// oldest history word lines up with the sliced bits.
	mlsd_checker u_mlsd (
		.clk        (clk),
		.rstb       (rstb),
		.codes_i    (hist[`DSP_HIST_WORDS-1]),
		.bits_i     (sliced_bits),
		.prev_bits_i(sliced_prev),
		.chest_i    (chest),
		.checked_o  (checked_bits_o)
	);

endmodule

/* mlsd/mlsd_checker.sv */
`timescale 1ns/10ps
`include "dsp_cfg.svh"

module mlsd_checker
	import dsp_pkg::*;
(
	input  logic           clk,
	input  logic           rstb,
	input  dsp_code_word_t codes_i,
	input  dsp_bits_t      bits_i,
	input  dsp_bits_t      prev_bits_i,
	input  dsp_chest_t     chest_i,
	output dsp_bits_t      checked_o
);
	// two estimate terms of either sign, then one more bit for the code difference.
	localparam int PRED_BITS = `DSP_CHEST_BITS + 2;
	localparam int DIFF_BITS = PRED_BITS + 1;

	// seq[l] is the bit before lane l, seq[l+1] is lane l itself.
	logic [`DSP_WIDTH:0] seq;
	dsp_bits_t checked_d;

	assign seq = {bits_i, prev_bits_i[`DSP_WIDTH-1]};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per lane hypothesis compare.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		logic b;
		logic p;
		logic signed [PRED_BITS-1:0] c0;
		logic signed [PRED_BITS-1:0] c1;
		logic signed [PRED_BITS-1:0] post;
		logic signed [PRED_BITS-1:0] pred_b;
		logic signed [PRED_BITS-1:0] pred_f;
		logic signed [DIFF_BITS-1:0] diff_b;
		logic signed [DIFF_BITS-1:0] diff_f;
		logic [DIFF_BITS-1:0] err_b;
		logic [DIFF_BITS-1:0] err_f;
		for (int l = 0; l < `DSP_WIDTH; l++) begin
			p = seq[l];
			b = seq[l + 1];
			c0 = $signed(chest_i[l][0]);
			c1 = $signed(chest_i[l][1]);
			// post-cursor term is shared by both hypotheses.
			post = p ? c1 : -c1;
			pred_b = (b ? c0 : -c0) + post;
			pred_f = (b ? -c0 : c0) + post;
			diff_b = $signed(codes_i[l]) - pred_b;
			diff_f = $signed(codes_i[l]) - pred_f;
			err_b = diff_b[DIFF_BITS-1] ? -diff_b : diff_b;
			err_f = diff_f[DIFF_BITS-1] ? -diff_f : diff_f;
			// ties keep the slicer bit.
			checked_d[l] = (err_f < err_b) ? ~b : b;
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			checked_o <= '0;
		end else begin
			checked_o <= checked_d;
		end
	end

endmodule

/* hdl/decision_slicer.sv */
`timescale 1ns/10ps
`include "dsp_cfg.svh"

module decision_slicer
	import dsp_pkg::*;
(
	input  logic             clk,
	input  logic             rstb,
	input  dsp_est_word_t    est_i,
	input  dsp_thresh_word_t thresh_i,
	output dsp_bits_t        bits_o,
	output dsp_bits_t        prev_bits_o
);

	dsp_bits_t bits_d;

	// bit is one at or above the lane threshold.
	always_comb begin
		for (int l = 0; l < `DSP_WIDTH; l++) begin
			bits_d[l] = ($signed(est_i[l]) >= $signed(thresh_i[l]));
		end
	end

	// prev_bits_o gives the MLSD the bit before lane 0.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			bits_o      <= '0;
			prev_bits_o <= '0;
		end else begin
			bits_o      <= bits_d;
			prev_bits_o <= bits_o;
		end
	end

endmodule

/* ffe/ffe_datapath.sv */
`timescale 1ns/10ps
`include "dsp_cfg.svh"

module ffe_datapath
	import dsp_pkg::*;
(
	input  logic            clk,
	input  logic            rstb,
	input  dsp_code_word_t  cur_i,
	input  dsp_code_word_t  prev_i,
	input  dsp_weights_t    weights_i,
	input  dsp_shift_word_t shift_i,
	output dsp_est_word_t   est_o
);
	localparam int ACC_BITS = `DSP_CODE_BITS + `DSP_WEIGHT_BITS + $clog2(`DSP_FFE_TAPS);
	localparam dsp_est_t EST_MAX = {1'b0, {(`DSP_EST_BITS-1){1'b1}}};
	localparam dsp_est_t EST_MIN = {1'b1, {(`DSP_EST_BITS-1){1'b0}}};

	// previous word in the low half, so older samples sit at lower indices.
	dsp_code_t [2*`DSP_WIDTH-1:0] window;
	dsp_est_word_t est_d;

	assign window = {cur_i, prev_i};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// multiply-accumulate, shift, saturate.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		logic signed [ACC_BITS-1:0] acc;
		logic signed [ACC_BITS-1:0] shifted;
		for (int l = 0; l < `DSP_WIDTH; l++) begin
			acc = '0;
			// tap k looks k samples back.
			for (int k = 0; k < `DSP_FFE_TAPS; k++) begin
				acc = acc + $signed(window[`DSP_WIDTH + l - k]) * $signed(weights_i[l][k]);
			end
			shifted = acc >>> shift_i[l];
			if (shifted > EST_MAX) begin
				est_d[l] = EST_MAX;
			end else if (shifted < EST_MIN) begin
				est_d[l] = EST_MIN;
			end else begin
				est_d[l] = shifted[`DSP_EST_BITS-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			est_o <= '0;
		end else begin
			est_o <= est_d;
		end
	end

endmodule

/* hdl/code_history.sv */
`timescale 1ns/10ps
`include "dsp_cfg.svh"

module code_history
	import dsp_pkg::*;
(
	input  logic           clk,
	input  logic           rstb,
	input  dsp_code_word_t codes_i,
	output dsp_code_hist_t hist_o
);

	// hist_o[0] is the newest word, each edge moves every word one slot older.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			hist_o <= '0;
		end else begin
			hist_o <= {hist_o[`DSP_HIST_WORDS-2:0], codes_i};
		end
	end

endmodule

/* hdl/dsp_config_regs.sv */
`timescale 1ns/10ps
`include "dsp_cfg.svh"

module dsp_config_regs
	import dsp_pkg::*;
(
	input  logic             clk,
	input  logic             rstb,
	input  logic             cfg_we_i,
	input  dsp_cfg_word_t    cfg_word_i,
	output dsp_weights_t     weights_o,
	output dsp_thresh_word_t thresh_o,
	output dsp_shift_word_t  ffe_shift_o,
	output dsp_chest_t       chest_o
);
	localparam int PL = `DSP_CFG_PAYLOAD_BITS;

	// clamp a signed payload into a signed field of the given width.
	function automatic logic signed [PL-1:0] sat_to(input logic signed [PL-1:0] v, input int bits);
		int hi;
		int lo;
		hi = (1 << (bits - 1)) - 1;
		lo = -(1 << (bits - 1));
		if (int'(v) > hi) begin
			return PL'(hi);
		end else if (int'(v) < lo) begin
			return PL'(lo);
		end
		return v;
	endfunction

	logic signed [PL-1:0] tap_val;
	logic signed [PL-1:0] wt_sat;
	logic signed [PL-1:0] ch_sat;
	logic signed [PL-1:0] th_sat;
	logic [`DSP_CFG_TAP_BITS-1:0] tap;
	logic [$clog2(`DSP_WIDTH)-1:0] lane;

	assign tap     = cfg_word_i.payload.tapped.tap;
	assign lane    = cfg_word_i.lane;
	assign tap_val = PL'($signed(cfg_word_i.payload.tapped.value));
	assign wt_sat  = sat_to(tap_val, `DSP_WEIGHT_BITS);
	assign ch_sat  = sat_to(tap_val, `DSP_CHEST_BITS);
	assign th_sat  = sat_to(cfg_word_i.payload.scalar, `DSP_EST_BITS);

	// out of range tap indices are dropped.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			weights_o   <= '0;
			thresh_o    <= '0;
			ffe_shift_o <= '0;
			chest_o     <= '0;
		end else if (cfg_we_i) begin
			unique case (cfg_word_i.target)
				CFG_WEIGHT: begin
					if (tap < `DSP_FFE_TAPS) begin
						weights_o[lane][tap] <= wt_sat[`DSP_WEIGHT_BITS-1:0];
					end
				end
				CFG_THRESH: begin
					thresh_o[lane] <= th_sat[`DSP_EST_BITS-1:0];
				end
				CFG_FFE_SHIFT: begin
					ffe_shift_o[lane] <= cfg_word_i.payload.scalar[`DSP_SHIFT_BITS-1:0];
				end
				CFG_CHEST: begin
					if (tap < `DSP_CHEST_TAPS) begin
						chest_o[lane][tap] <= ch_sat[`DSP_CHEST_BITS-1:0];
					end
				end
			endcase
		end
	end

endmodule

/* common/dsp_pkg.sv */
`include "dsp_cfg.svh"

package dsp_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// configuration word.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		CFG_WEIGHT    = 2'd0,
		CFG_THRESH    = 2'd1,
		CFG_FFE_SHIFT = 2'd2,
		CFG_CHEST     = 2'd3
	} dsp_cfg_target_e;

	typedef struct packed {
		logic [`DSP_CFG_TAP_BITS-1:0]          tap;
		logic signed [`DSP_CFG_VALUE_BITS-1:0] value;
	} dsp_cfg_tapped_t;

	// weights and channel estimate use tapped, threshold and shift use scalar.
	typedef union packed {
		dsp_cfg_tapped_t                         tapped;
		logic signed [`DSP_CFG_PAYLOAD_BITS-1:0] scalar;
	} dsp_cfg_payload_u;

	typedef struct packed {
		dsp_cfg_target_e               target;
		logic [$clog2(`DSP_WIDTH)-1:0] lane;
		dsp_cfg_payload_u              payload;
	} dsp_cfg_word_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lane arrays. lane 0 is the earliest sample.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic signed [`DSP_CODE_BITS-1:0] dsp_code_t;
	typedef dsp_code_t [`DSP_WIDTH-1:0] dsp_code_word_t;
	typedef dsp_code_word_t [`DSP_HIST_WORDS-1:0] dsp_code_hist_t;

	typedef logic signed [`DSP_EST_BITS-1:0] dsp_est_t;
	typedef dsp_est_t [`DSP_WIDTH-1:0] dsp_est_word_t;
	typedef logic [`DSP_WIDTH-1:0] dsp_bits_t;

	typedef logic signed [`DSP_WEIGHT_BITS-1:0] dsp_weight_t;
	typedef dsp_weight_t [`DSP_FFE_TAPS-1:0] dsp_lane_weights_t;
	typedef dsp_lane_weights_t [`DSP_WIDTH-1:0] dsp_weights_t;

	typedef logic signed [`DSP_CHEST_BITS-1:0] dsp_chest_tap_t;
	typedef dsp_chest_tap_t [`DSP_CHEST_TAPS-1:0] dsp_lane_chest_t;
	typedef dsp_lane_chest_t [`DSP_WIDTH-1:0] dsp_chest_t;

	typedef dsp_est_t [`DSP_WIDTH-1:0] dsp_thresh_word_t;
	typedef logic [`DSP_WIDTH-1:0][`DSP_SHIFT_BITS-1:0] dsp_shift_word_t;

endpackage

/* common/dsp_cfg.svh */
`ifndef DSP_CFG_SVH
`define DSP_CFG_SVH

// lanes per word and ADC code width.
`define DSP_WIDTH 4
`define DSP_CODE_BITS 8

// feed-forward equalizer.
`define DSP_FFE_TAPS 3
`define DSP_WEIGHT_BITS 8
`define DSP_SHIFT_BITS 4
`define DSP_EST_BITS 10

// channel estimate, cursor and first post-cursor.
`define DSP_CHEST_TAPS 2
`define DSP_CHEST_BITS 8

// code words kept for the FFE window and MLSD alignment.
`define DSP_HIST_WORDS 3

// configuration payload split.
`define DSP_CFG_PAYLOAD_BITS 16
`define DSP_CFG_TAP_BITS 4
`define DSP_CFG_VALUE_BITS 12

`endif
